//--- Bender.yml
package:
  name: dcache

sources:
  - files:
      - common/dcache_pkg.sv
      - logic/tag_lookup.sv
      - burst/burst_sequencer.sv
      - logic/line_store.sv
      - logic/dcache_top.sv
  - target: test
    files:
      - verif/bus_memory.sv
      - verif/dcache_tb.sv

//--- burst/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer (
    input  wire logic                  CLK,
    input  wire logic                  RES,
    input  wire logic                  miss_start,
    input  wire logic                  victim_valid,
    input  wire dcache_pkg::tag_t      victim_tag,
    input  wire dcache_pkg::tag_t      fill_tag,
    input  wire dcache_pkg::line_t     line_q,
    input  wire dcache_pkg::byte_t     bus_rdata,
    input  wire logic                  bus_rdy,
    output logic                       bus_req,
    output logic                       bus_write,
    output dcache_pkg::bus_addr_t      bus_addr,
    output dcache_pkg::byte_t          bus_wdata,
    output logic                       fill_done,
    output dcache_pkg::line_t          fill_line
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_WBACK,
        PH_REFILL
    } phase_t;

    localparam dcache_pkg::offset_t LAST_BEAT = dcache_pkg::offset_t'(dcache_pkg::BEAT_COUNT - 1);

    phase_t                 phase;
    dcache_pkg::offset_t    beat;
    dcache_pkg::line_t      victim_line;
    dcache_pkg::tag_t       wb_tag;
    dcache_pkg::tag_t       rf_tag;
    logic                   beat_done;

    // A beat is taken when the bus is ready
    assign beat_done = bus_req && bus_rdy;

    // ==============================
    // Bus drive
    // ==============================

    // Address and data come from registers, so they hold through stalls
    always_comb
    begin
        bus_req   = 1'b0;
        bus_write = 1'b0;
        bus_addr  = '0;
        bus_wdata = '0;
        case (phase)
            PH_WBACK:
            begin
                bus_req   = 1'b1;
                bus_write = 1'b1;
                bus_addr  = {dcache_pkg::DATA_REGION, wb_tag, beat};
                bus_wdata = victim_line[8*beat +: 8];
            end
            PH_REFILL:
            begin
                bus_req  = 1'b1;
                bus_addr = {dcache_pkg::DATA_REGION, rf_tag, beat};
            end
            default:
            begin
                bus_req = 1'b0;
            end
        endcase
    end

    // ==============================
    // Phase and beat counter
    // ==============================

    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            phase     <= PH_IDLE;
            beat      <= '0;
            fill_done <= 1'b0;
        end
        else
        begin
            fill_done <= 1'b0;
            case (phase)
                PH_IDLE:
                begin
                    if (miss_start)
                    begin
                        // Clean start skips the write-back
                        phase <= victim_valid ? PH_WBACK : PH_REFILL;
                        beat  <= '0;
                    end
                end
                PH_WBACK:
                begin
                    if (beat_done && (beat == LAST_BEAT))
                    begin
                        phase <= PH_REFILL;
                        beat  <= '0;
                    end
                    else if (beat_done)
                        beat <= beat + 1'b1;
                end
                PH_REFILL:
                begin
                    if (beat_done && (beat == LAST_BEAT))
                    begin
                        phase     <= PH_IDLE;
                        beat      <= '0;
                        fill_done <= 1'b1;
                    end
                    else if (beat_done)
                        beat <= beat + 1'b1;
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // Victim snapshot and line addresses at miss start
    always_ff @(posedge CLK)
    begin
        if ((phase == PH_IDLE) && miss_start)
        begin
            victim_line <= line_q;
            wb_tag      <= victim_tag;
            rf_tag      <= fill_tag;
        end
    end

    // Refill bytes land in beat order
    always_ff @(posedge CLK)
    begin
        if ((phase == PH_REFILL) && beat_done)
            fill_line[8*beat +: 8] <= bus_rdata;
    end

endmodule

`default_nettype wire

//--- common/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ==============================
    // Cache geometry
    // ==============================

    // One direct-mapped line
    localparam int LINE_BYTES = 8;

    // Bus beats per burst, one byte each
    localparam int BEAT_COUNT = 8;

    // ==============================
    // Address and data types
    // ==============================

    // CPU data port covers 32 KB
    typedef logic [14:0] dm_addr_t;

    // External bus covers 64 KB
    typedef logic [15:0] bus_addr_t;

    // Upper 12 bits of a CPU address
    typedef logic [11:0] tag_t;

    // Byte within a line, also the beat index
    typedef logic [2:0] offset_t;

    typedef logic [7:0] byte_t;
    typedef logic [63:0] line_t;

    // Bus address MSB that selects the data half of external memory
    localparam logic DATA_REGION = 1'b1;

endpackage

`default_nettype wire

//--- logic/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  wire logic                  CLK,
    input  wire logic                  RES,
    // CPU data port
    input  wire logic                  dm_req,
    input  wire logic                  dm_write,
    input  wire dcache_pkg::dm_addr_t  dm_addr,
    input  wire dcache_pkg::byte_t     dm_wdata,
    output dcache_pkg::byte_t          dm_rdata,
    output logic                       dm_rdy,
    // External byte bus
    output logic                       bus_req,
    output logic                       bus_write,
    output dcache_pkg::bus_addr_t      bus_addr,
    output dcache_pkg::byte_t          bus_wdata,
    input  wire dcache_pkg::byte_t     bus_rdata,
    input  wire logic                  bus_rdy
);

    // Lookup to line store
    logic                   hit_op;
    logic                   op_write;
    dcache_pkg::offset_t    op_offset;
    dcache_pkg::byte_t      op_wdata;

    // Lookup to sequencer
    logic                   miss_start;
    logic                   victim_valid;
    dcache_pkg::tag_t       victim_tag;
    dcache_pkg::tag_t       fill_tag;

    // Sequencer back to lookup and line store
    logic                   fill_done;
    dcache_pkg::line_t      fill_line;

    // Resident line for write-back
    dcache_pkg::line_t      line_q;

    tag_lookup u_tag_lookup (
        .CLK          (CLK),
        .RES          (RES),
        .dm_req       (dm_req),
        .dm_write     (dm_write),
        .dm_addr      (dm_addr),
        .dm_wdata     (dm_wdata),
        .fill_done    (fill_done),
        .hit_op       (hit_op),
        .op_write     (op_write),
        .op_offset    (op_offset),
        .op_wdata     (op_wdata),
        .miss_start   (miss_start),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .fill_tag     (fill_tag)
    );

    burst_sequencer u_burst_sequencer (
        .CLK          (CLK),
        .RES          (RES),
        .miss_start   (miss_start),
        .victim_valid (victim_valid),
        .victim_tag   (victim_tag),
        .fill_tag     (fill_tag),
        .line_q       (line_q),
        .bus_rdata    (bus_rdata),
        .bus_rdy      (bus_rdy),
        .bus_req      (bus_req),
        .bus_write    (bus_write),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .fill_done    (fill_done),
        .fill_line    (fill_line)
    );

    line_store u_line_store (
        .CLK          (CLK),
        .RES          (RES),
        .hit_op       (hit_op),
        .op_write     (op_write),
        .op_offset    (op_offset),
        .op_wdata     (op_wdata),
        .fill_done    (fill_done),
        .fill_line    (fill_line),
        .line_q       (line_q),
        .dm_rdata     (dm_rdata),
        .dm_rdy       (dm_rdy)
    );

endmodule

`default_nettype wire

//--- logic/line_store.sv
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  wire logic                  CLK,
    input  wire logic                  RES,
    input  wire logic                  hit_op,
    input  wire logic                  op_write,
    input  wire dcache_pkg::offset_t   op_offset,
    input  wire dcache_pkg::byte_t     op_wdata,
    input  wire logic                  fill_done,
    input  wire dcache_pkg::line_t     fill_line,
    output dcache_pkg::line_t          line_q,
    output dcache_pkg::byte_t          dm_rdata,
    output logic                       dm_rdy
);

    dcache_pkg::line_t  line_d;
    dcache_pkg::line_t  merged;
    dcache_pkg::byte_t  rd_byte;

    assign line_q = line_d;

    // ==============================
    // Byte select and merge
    // ==============================

    always_comb
    begin
        rd_byte = '0;
        merged  = line_d;
        for (int i = 0; i < dcache_pkg::LINE_BYTES; i++)
        begin
            if (op_offset == dcache_pkg::offset_t'(i))
            begin
                rd_byte          = line_d[8*i +: 8];
                merged[8*i +: 8] = op_wdata;
            end
        end
    end

    // Refill replaces the whole line, a write hit changes one byte
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
            line_d <= '0;
        else if (fill_done)
            line_d <= fill_line;
        else if (hit_op && op_write)
            line_d <= merged;
    end

    // ==============================
    // CPU response
    // ==============================

    // One-cycle ready, read data zero on writes
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            dm_rdy   <= 1'b0;
            dm_rdata <= '0;
        end
        else
        begin
            dm_rdy   <= hit_op;
            dm_rdata <= (hit_op && !op_write) ? rd_byte : '0;
        end
    end

endmodule

`default_nettype wire

//--- logic/tag_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module tag_lookup (
    input  wire logic                  CLK,
    input  wire logic                  RES,
    input  wire logic                  dm_req,
    input  wire logic                  dm_write,
    input  wire dcache_pkg::dm_addr_t  dm_addr,
    input  wire dcache_pkg::byte_t     dm_wdata,
    input  wire logic                  fill_done,
    output logic                       hit_op,
    output logic                       op_write,
    output dcache_pkg::offset_t        op_offset,
    output dcache_pkg::byte_t          op_wdata,
    output logic                       miss_start,
    output logic                       victim_valid,
    output dcache_pkg::tag_t           victim_tag,
    output dcache_pkg::tag_t           fill_tag
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HOLD,
        ST_MISS
    } state_t;

    state_t             state;
    dcache_pkg::tag_t   tag_q;
    logic               valid_q;
    dcache_pkg::tag_t   req_tag;
    logic               tag_match;

    assign req_tag   = dm_addr[14:3];
    assign tag_match = valid_q && (tag_q == req_tag);

    // ==============================
    // Request decode
    // ==============================

    // Only an idle lookup looks at the request
    assign hit_op     = (state == ST_IDLE) && dm_req && tag_match;
    assign miss_start = (state == ST_IDLE) && dm_req && !tag_match;

    // CPU holds these until dm_rdy, so they pass straight on
    assign op_write  = dm_write;
    assign op_offset = dm_addr[2:0];
    assign op_wdata  = dm_wdata;

    // Victim is the resident line, fill target is the held request
    assign victim_valid = valid_q;
    assign victim_tag   = tag_q;
    assign fill_tag     = req_tag;

    // Hold covers the dm_rdy cycle, when the old request is still up
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (hit_op)
                        state <= ST_HOLD;
                    else if (miss_start)
                        state <= ST_MISS;
                end
                ST_HOLD:
                    state <= ST_IDLE;
                ST_MISS:
                begin
                    // Replay as a hit in the next cycle
                    if (fill_done)
                        state <= ST_IDLE;
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Tag and valid follow the refill
    always_ff @(posedge CLK or posedge RES)
    begin
        if (RES)
        begin
            valid_q <= 1'b0;
            tag_q   <= '0;
        end
        else if (fill_done)
        begin
            valid_q <= 1'b1;
            tag_q   <= req_tag;
        end
    end

endmodule

`default_nettype wire

//--- verif/bus_memory.sv
`timescale 1ns/1ps
`default_nettype none

module bus_memory #(
    parameter logic [7:0] FILL_XOR = 8'hA5
) (
    input  wire logic                   CLK,
    input  wire logic                   bus_req,
    input  wire logic                   bus_write,
    input  wire dcache_pkg::bus_addr_t  bus_addr,
    input  wire dcache_pkg::byte_t      bus_wdata,
    output dcache_pkg::byte_t           bus_rdata,
    output logic                        bus_rdy
);

    dcache_pkg::byte_t      mem [0:65535];
    dcache_pkg::bus_addr_t  fill_addr;

    // Pattern mixes both address bytes
    initial
    begin
        bus_rdy = 1'b0;
        for (int i = 0; i < 65536; i++)
        begin
            fill_addr = dcache_pkg::bus_addr_t'(i);
            mem[i]    = fill_addr[7:0] ^ fill_addr[15:8] ^ FILL_XOR;
        end
    end

    // Roughly one cycle in three stalls
    always @(negedge CLK)
        bus_rdy = ($urandom_range(2, 0) != 0);

    // Read data valid in the accepting cycle
    assign bus_rdata = mem[bus_addr];

    always @(posedge CLK)
    begin
        if (bus_req && bus_rdy && bus_write)
            mem[bus_addr] <= bus_wdata;
    end

endmodule

`default_nettype wire

//--- verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 8;
    localparam int          DIRECTED_OPS = 12;
    localparam int          RANDOM_OPS   = 300;
    localparam int          TOTAL_OPS    = DIRECTED_OPS + RANDOM_OPS;
    localparam logic [7:0]  FILL_XOR     = 8'hA5;
    localparam dcache_pkg::dm_addr_t LINE_A = 15'h0120;
    localparam dcache_pkg::dm_addr_t LINE_B = 15'h1A40;

    logic                   CLK = 1'b0;
    logic                   RES;
    logic                   dm_req;
    logic                   dm_write;
    dcache_pkg::dm_addr_t   dm_addr;
    dcache_pkg::byte_t      dm_wdata;
    dcache_pkg::byte_t      dm_rdata;
    logic                   dm_rdy;
    logic                   bus_req;
    logic                   bus_write;
    dcache_pkg::bus_addr_t  bus_addr;
    dcache_pkg::byte_t      bus_wdata;
    dcache_pkg::byte_t      bus_rdata;
    logic                   bus_rdy;

    // Model of the data region as the CPU sees it
    dcache_pkg::byte_t      ref_mem [0:32767];
    dcache_pkg::byte_t      exp_q[$];
    string                  name_q[$];
    int                     issued;
    int                     answered;
    int                     wr_beats;
    int                     rd_beats;
    int                     wb_end_rd;
    dcache_pkg::offset_t    beat_idx;
    logic                   burst_write;
    dcache_pkg::tag_t       burst_line;
    dcache_pkg::tag_t       last_wr_line;
    dcache_pkg::tag_t       last_rd_line;

    dcache_top dut0 (
        .CLK       (CLK),
        .RES       (RES),
        .dm_req    (dm_req),
        .dm_write  (dm_write),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata),
        .dm_rdata  (dm_rdata),
        .dm_rdy    (dm_rdy),
        .bus_req   (bus_req),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_rdy   (bus_rdy)
    );

    bus_memory #(.FILL_XOR(FILL_XOR)) mem0 (
        .CLK       (CLK),
        .bus_req   (bus_req),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_rdy   (bus_rdy)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ==============================
    // Reference model and helpers
    // ==============================

    function automatic dcache_pkg::bus_addr_t data_bus_addr(dcache_pkg::dm_addr_t a);
        return {dcache_pkg::DATA_REGION, a};
    endfunction

    function automatic dcache_pkg::byte_t fill_byte(dcache_pkg::bus_addr_t a);
        return a[7:0] ^ a[15:8] ^ FILL_XOR;
    endfunction

    // Applies one CPU access and returns the expected dm_rdata
    function automatic dcache_pkg::byte_t model_access(logic write, dcache_pkg::dm_addr_t a,
                                                       dcache_pkg::byte_t wdata);
        if (write)
        begin
            ref_mem[a] = wdata;
            return '0;
        end
        return ref_mem[a];
    endfunction

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(string test, logic [31:0] expected, logic [31:0] actual);
        abort_run($sformatf("FAILED %s: expected 0x%0h, actual 0x%0h", test, expected, actual));
    endtask

    // Drives one request and returns at the falling edge that shows dm_rdy
    task automatic cpu_access(string test, logic write, dcache_pkg::dm_addr_t a,
                              dcache_pkg::byte_t wdata, output int cycles);
        dm_req   = 1'b1;
        dm_write = write;
        dm_addr  = a;
        dm_wdata = wdata;
        exp_q.push_back(model_access(write, a, wdata));
        name_q.push_back(test);
        issued++;
        cycles = 0;
        do
        begin
            @(negedge CLK);
            cycles++;
        end
        while (!dm_rdy);
    endtask

    task automatic idle_cycles(int n);
        dm_req = 1'b0;
        repeat (n) @(negedge CLK);
    endtask

    // ==============================
    // Response and bus checks
    // ==============================

    always @(negedge CLK)
    begin
        if (!RES && dm_rdy)
        begin
            assert (exp_q.size() > 0)
            else abort_run("dm_rdy pulsed with no request outstanding");
            assert (dm_rdata === exp_q[0])
            else fail_value(name_q[0], exp_q[0], dm_rdata);
            exp_q.delete(0);
            name_q.delete(0);
            answered++;
        end
    end

    // Beat values are taken just before the rising edge that accepts them
    always @(posedge CLK)
    begin
        if (!RES && bus_req && bus_rdy)
        begin
            assert (bus_addr[15] == dcache_pkg::DATA_REGION)
            else fail_value("bus region bit", dcache_pkg::DATA_REGION, bus_addr[15]);
            assert (bus_addr[2:0] == beat_idx)
            else fail_value("beat offset", beat_idx, bus_addr[2:0]);
            if (beat_idx == 3'd0)
            begin
                burst_line  = bus_addr[14:3];
                burst_write = bus_write;
            end
            assert ((bus_addr[14:3] == burst_line) && (bus_write == burst_write))
            else abort_run("A bus burst changed line or direction before its eighth beat");
            if (bus_write)
            begin
                assert (bus_wdata === ref_mem[bus_addr[14:0]])
                else fail_value("write-back data", ref_mem[bus_addr[14:0]], bus_wdata);
                wr_beats++;
            end
            else
                rd_beats++;
            if (beat_idx == 3'd7)
            begin
                if (burst_write)
                begin
                    last_wr_line = burst_line;
                    wb_end_rd    = rd_beats;
                end
                else
                    last_rd_line = burst_line;
            end
            beat_idx = beat_idx + 1'b1;
        end
    end

    initial
    begin : watchdog
        #(TOTAL_OPS * 40 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        abort_run("Watchdog expired, the run hung waiting for the cache");
    end

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin : stimulus
        int                     cycles;
        int                     i;
        int                     wr_before;
        int                     rd_before;
        logic                   w;
        dcache_pkg::dm_addr_t   a;
        dcache_pkg::tag_t       lines [4];

        void'($urandom(35057));
        RES          = 1'b1;
        dm_req       = 1'b0;
        dm_write     = 1'b0;
        dm_addr      = '0;
        dm_wdata     = '0;
        issued       = 0;
        answered     = 0;
        wr_beats     = 0;
        rd_beats     = 0;
        wb_end_rd    = 0;
        beat_idx     = '0;
        burst_write  = 1'b0;
        burst_line   = '0;
        last_wr_line = '0;
        last_rd_line = '0;
        for (i = 0; i < 32768; i++)
            ref_mem[i] = fill_byte(data_bus_addr(dcache_pkg::dm_addr_t'(i)));
        repeat (RESET_CYCLES) @(negedge CLK);
        RES = 1'b0;
        @(negedge CLK);

        // First access misses on an empty cache
        assert (dm_rdy === 1'b0) else fail_value("reset dm_rdy", 0, dm_rdy);
        assert (bus_req === 1'b0) else fail_value("reset bus_req", 0, bus_req);
        a = LINE_A + 15'd3;
        cpu_access("first miss", 1'b0, a, '0, cycles);
        assert (rd_beats == 8) else fail_value("first miss read beats", 8, rd_beats);
        assert (wr_beats == 0) else fail_value("first miss write beats", 0, wr_beats);
        assert (last_rd_line == a[14:3])
        else fail_value("first miss line", a[14:3], last_rd_line);

        idle_cycles(1);
        rd_before = rd_beats;
        cpu_access("read hit", 1'b0, LINE_A + 15'd5, '0, cycles);
        assert (cycles == 1) else fail_value("read hit latency", 1, cycles);
        assert ((rd_beats == rd_before) && (bus_req === 1'b0))
        else abort_run("The bus was used on a read hit");

        cpu_access("write hit", 1'b1, LINE_A + 15'd6, 8'h3C, cycles);
        for (i = 0; i < 8; i++)
            cpu_access($sformatf("line readback %0d", i), 1'b0,
                       LINE_A + dcache_pkg::dm_addr_t'(i), '0, cycles);

        // Dirty line goes out before the new one comes in
        idle_cycles(1);
        wr_before = wr_beats;
        rd_before = rd_beats;
        a = LINE_B + 15'd7;
        cpu_access("eviction", 1'b0, a, '0, cycles);
        assert (wr_beats - wr_before == 8)
        else fail_value("eviction write beats", 8, wr_beats - wr_before);
        assert (rd_beats - rd_before == 8)
        else fail_value("eviction read beats", 8, rd_beats - rd_before);
        assert (wb_end_rd == rd_before)
        else abort_run("The refill started before the write-back had finished");
        assert (last_wr_line == LINE_A[14:3])
        else fail_value("eviction victim line", LINE_A[14:3], last_wr_line);
        assert (last_rd_line == a[14:3])
        else fail_value("eviction fill line", a[14:3], last_rd_line);
        for (i = 0; i < 8; i++)
        begin
            a = LINE_A + dcache_pkg::dm_addr_t'(i);
            assert (mem0.mem[data_bus_addr(a)] === ref_mem[a])
            else fail_value("old line in memory", ref_mem[a], mem0.mem[data_bus_addr(a)]);
        end

        // Random mix over four lines with some back-to-back requests
        lines[0] = LINE_A[14:3];
        lines[1] = LINE_B[14:3];
        lines[2] = 12'hFFF;
        lines[3] = 12'h141;
        for (i = 0; i < RANDOM_OPS; i++)
        begin
            w = $urandom_range(1, 0);
            a = {lines[$urandom_range(3, 0)], 3'($urandom_range(7, 0))};
            cpu_access($sformatf("random op %0d", i), w, a, 8'($urandom), cycles);
            if ($urandom_range(3, 0) == 0)
                idle_cycles(1);
        end
        idle_cycles(2);

        if ((answered == issued) && (exp_q.size() == 0))
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
        else
            abort_run("Some requests never received dm_rdy");
    end

endmodule

`default_nettype wire

//--- vlog.f
common/dcache_pkg.sv
logic/tag_lookup.sv
burst/burst_sequencer.sv
logic/line_store.sv
logic/dcache_top.sv
verif/bus_memory.sv
verif/dcache_tb.sv
